// File: all.f
hw/commit_pkg.sv
hw/commit_if.sv
hw/retire_queue.sv
hw/commit_stage.sv
hw/regfile.sv
hw/csr_unit.sv
hw/store_commit_buffer.sv
hw/commit_top.sv
tb/commit_tb.sv

// File: hw/commit_if.sv
interface commit_if import commit_pkg::*; ();

    // two oldest queue entries, valid clear when a slot is empty
    scoreboard_entry_t [NR_COMMIT_PORTS-1:0] commit_instr;
    // ack[1] only ever set together with ack[0]
    logic [NR_COMMIT_PORTS-1:0]              commit_ack;
    // empties the queue at the same edge
    logic                                    flush;

    modport queue (
        output commit_instr,
        input  commit_ack,
        input  flush
    );

    modport commit (
        input  commit_instr,
        output commit_ack,
        output flush
    );

endinterface

// File: hw/commit_pkg.sv
package commit_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned XLEN            = 64;
    localparam int unsigned RQ_DEPTH        = 8;
    localparam int unsigned RQ_PTR_W        = $clog2(RQ_DEPTH);
    localparam int unsigned SB_DEPTH        = 2;
    localparam int unsigned SB_DRAIN_CYCLES = 3;
    // count must also hold the full value
    localparam int unsigned SB_CNT_W        = $clog2(SB_DEPTH + 1);
    localparam int unsigned SB_TMR_W        = $clog2(SB_DRAIN_CYCLES);

    // machine mode csr addresses
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;

    // trap causes, msb marks an interrupt
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 64'd2;
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INT     = {1'b1, 63'd11};

    // --------------------
    // types
    // --------------------
    typedef enum logic [2:0] {
        NONE, ALU, LOAD, STORE, CTRL_FLOW, MULT, CSR
    } fu_t;

    // ADD on a csr instruction is the csr no-op (plain read)
    typedef enum logic [2:0] {
        ADD, CSR_WRITE, CSR_SET, CSR_CLEAR, FENCE, MRET, OTHER
    } fu_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // csr instructions carry the write operand in result
    // and the csr address in ex.tval[11:0]
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        fu_t             fu;
        fu_op_t          op;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
        exception_t      ex;
    } scoreboard_entry_t;

endpackage

// File: hw/commit_stage.sv
module commit_stage import commit_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 halt_i,
    input  logic                                 single_step_i,
    commit_if.commit                             commit,
    // register file
    output logic [NR_COMMIT_PORTS-1:0][4:0]      waddr_o,
    output logic [NR_COMMIT_PORTS-1:0][XLEN-1:0] wdata_o,
    output logic [NR_COMMIT_PORTS-1:0]           we_o,
    // csr unit
    output fu_op_t                               csr_op_o,
    output logic [11:0]                          csr_addr_o,
    output logic [XLEN-1:0]                      csr_wdata_o,
    output logic                                 commit_csr_o,
    input  logic [XLEN-1:0]                      csr_rdata_i,
    input  exception_t                           csr_exception_i,
    output logic [XLEN-1:0]                      commit_pc_o,
    // store buffer
    output logic                                 commit_lsu_o,
    input  logic                                 commit_lsu_ready_i,
    input  logic                                 no_st_pending_i,
    output logic                                 fence_o,
    output exception_t                           exception_o
);

    scoreboard_entry_t [NR_COMMIT_PORTS-1:0] instr;
    logic [NR_COMMIT_PORTS-1:0]              ack;

    assign instr             = commit.commit_instr;
    assign commit.commit_ack = ack;
    // a taken trap drops everything younger
    assign commit.flush      = exception_o.valid;

    assign waddr_o[0]  = instr[0].rd;
    assign waddr_o[1]  = instr[1].rd;
    assign commit_pc_o = instr[0].pc;
    assign csr_addr_o  = instr[0].ex.tval[11:0];

    // --------------------
    // retire decision
    // --------------------
    always_comb begin : retire
        ack          = '0;
        we_o         = '0;
        commit_lsu_o = 1'b0;
        commit_csr_o = 1'b0;
        fence_o      = 1'b0;
        wdata_o[0]   = instr[0].result;
        wdata_o[1]   = instr[1].result;
        // csr no-op by default
        csr_op_o     = ADD;
        csr_wdata_o  = '0;

        // port 0
        if (instr[0].valid && !halt_i) begin
            ack[0] = 1'b1;
            // a trapping instruction is acked but leaves no state behind
            if (!exception_o.valid) begin
                if (instr[0].fu == STORE) begin
                    // wait on store buffer back-pressure
                    commit_lsu_o = commit_lsu_ready_i;
                    ack[0]       = commit_lsu_ready_i;
                end
                if (instr[0].op == FENCE) begin
                    // hold until all committed stores have drained
                    fence_o = no_st_pending_i;
                    ack[0]  = no_st_pending_i;
                end
            end
            if (instr[0].fu == CSR) begin
                commit_csr_o = 1'b1;
                wdata_o[0]   = csr_rdata_i;
                csr_op_o     = instr[0].op;
                csr_wdata_o  = instr[0].result;
            end
            we_o[0] = ack[0] && !exception_o.valid;
        end

        // port 1, plain result writers only, behind a clean port 0
        if (ack[0] && instr[1].valid && !halt_i && !single_step_i
                && (instr[0].fu != CSR)
                && !exception_o.valid && !instr[1].ex.valid
                && (instr[1].fu inside {ALU, LOAD, CTRL_FLOW, MULT})) begin
            ack[1]  = 1'b1;
            we_o[1] = 1'b1;
        end
    end

    // --------------------
    // trap selection
    // --------------------
    // lowest priority first, later assignments override
    always_comb begin : trap
        exception_o = '0;
        // a trap needs a valid pc to return to
        if (instr[0].valid) begin
            if (csr_exception_i.valid && !csr_exception_i.cause[XLEN-1]) begin
                exception_o      = csr_exception_i;
                exception_o.tval = instr[0].ex.tval;
            end
            // exception raised earlier in the pipe
            if (instr[0].ex.valid) begin
                exception_o = instr[0].ex;
            end
            // interrupts beat everything
            if (csr_exception_i.valid && csr_exception_i.cause[XLEN-1]) begin
                exception_o      = csr_exception_i;
                exception_o.tval = instr[0].ex.tval;
            end
        end
        if (halt_i) begin
            exception_o.valid = 1'b0;
        end
    end

    // queue fills from the oldest slot so slot 1 is never valid alone
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit.commit_instr[1].valid |-> commit.commit_instr[0].valid);

endmodule

// File: hw/commit_top.sv
module commit_top import commit_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    // issue side
    input  logic            issue_valid_i,
    input  logic [XLEN-1:0] issue_pc_i,
    input  fu_t             issue_fu_i,
    input  fu_op_t          issue_op_i,
    input  logic [4:0]      issue_rd_i,
    input  logic [XLEN-1:0] issue_result_i,
    input  logic            issue_ex_valid_i,
    input  logic [XLEN-1:0] issue_ex_cause_i,
    input  logic [XLEN-1:0] issue_ex_tval_i,
    output logic            issue_ready_o,
    // control
    input  logic            halt_i,
    input  logic            single_step_i,
    input  logic            irq_i,
    // observation
    input  logic [4:0]      rf_raddr_i,
    output logic [XLEN-1:0] rf_rdata_o,
    output logic [1:0]      retire_count_o,
    output logic            store_drained_o,
    output logic            fence_o,
    output logic            exc_valid_o,
    output logic [XLEN-1:0] exc_cause_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o,
    output logic [XLEN-1:0] csr_rdata_o
);

    scoreboard_entry_t                    issue_entry;
    logic [NR_COMMIT_PORTS-1:0][4:0]      rf_waddr;
    logic [NR_COMMIT_PORTS-1:0][XLEN-1:0] rf_wdata;
    logic [NR_COMMIT_PORTS-1:0]           rf_we;
    fu_op_t                               csr_op;
    logic [11:0]                          csr_addr;
    logic [XLEN-1:0]                      csr_wdata;
    logic                                 commit_csr;
    exception_t                           csr_exception;
    logic [XLEN-1:0]                      commit_pc;
    logic                                 commit_lsu;
    logic                                 commit_lsu_ready;
    logic                                 no_st_pending;
    exception_t                           exception;

    commit_if commit_bus ();

    assign issue_entry = '{valid: 1'b1, pc: issue_pc_i, fu: issue_fu_i, op: issue_op_i,
                           rd: issue_rd_i, result: issue_result_i,
                           ex: '{valid: issue_ex_valid_i, cause: issue_ex_cause_i,
                                 tval: issue_ex_tval_i}};

    assign retire_count_o = {1'b0, commit_bus.commit_ack[0]} + {1'b0, commit_bus.commit_ack[1]};
    assign exc_valid_o    = exception.valid;
    assign exc_cause_o    = exception.cause;

    retire_queue u_queue (
        .clk_i, .rst_i, .issue_valid_i, .issue_entry_i(issue_entry), .issue_ready_o,
        .commit(commit_bus.queue)
    );

    commit_stage u_commit (
        .clk_i, .rst_i, .halt_i, .single_step_i, .commit(commit_bus.commit),
        .waddr_o(rf_waddr), .wdata_o(rf_wdata), .we_o(rf_we),
        .csr_op_o(csr_op), .csr_addr_o(csr_addr), .csr_wdata_o(csr_wdata),
        .commit_csr_o(commit_csr), .csr_rdata_i(csr_rdata_o),
        .csr_exception_i(csr_exception), .commit_pc_o(commit_pc),
        .commit_lsu_o(commit_lsu), .commit_lsu_ready_i(commit_lsu_ready),
        .no_st_pending_i(no_st_pending), .fence_o, .exception_o(exception)
    );

    regfile u_regfile (
        .clk_i, .rst_i, .waddr_i(rf_waddr), .wdata_i(rf_wdata), .we_i(rf_we),
        .raddr_i(rf_raddr_i), .rdata_o(rf_rdata_o)
    );

    csr_unit u_csr (
        .clk_i, .rst_i, .irq_i, .csr_op_i(csr_op), .csr_addr_i(csr_addr),
        .csr_wdata_i(csr_wdata), .commit_csr_i(commit_csr),
        .commit_head_valid_i(commit_bus.commit_instr[0].valid), .commit_pc_i(commit_pc),
        .exception_i(exception), .csr_rdata_o, .csr_exception_o(csr_exception),
        .mepc_o, .mcause_o
    );

    store_commit_buffer u_store_buf (
        .clk_i, .rst_i, .commit_lsu_i(commit_lsu), .commit_lsu_ready_o(commit_lsu_ready),
        .no_st_pending_o(no_st_pending), .drained_o(store_drained_o)
    );

endmodule

// File: hw/csr_unit.sv
module csr_unit import commit_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            irq_i,
    input  fu_op_t          csr_op_i,
    input  logic [11:0]     csr_addr_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    input  logic            commit_csr_i,
    input  logic            commit_head_valid_i,
    input  logic [XLEN-1:0] commit_pc_i,
    input  exception_t      exception_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output exception_t      csr_exception_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o
);

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] csr_wval;
    logic            csr_known;
    logic            csr_we;
    logic            csr_ro;

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

    // --------------------
    // read and modify
    // --------------------
    always_comb begin : csr_read
        csr_known   = 1'b1;
        csr_rdata_o = '0;
        case (csr_addr_i)
            CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            CSR_MEPC:     csr_rdata_o = mepc_q;
            CSR_MCAUSE:   csr_rdata_o = mcause_q;
            CSR_MTVEC:    csr_rdata_o = mtvec_q;
            default:      csr_known   = 1'b0;
        endcase
    end

    assign csr_we = csr_op_i inside {CSR_WRITE, CSR_SET, CSR_CLEAR};
    // trap state is only written by hardware
    assign csr_ro = csr_addr_i inside {CSR_MEPC, CSR_MCAUSE};

    always_comb begin : csr_modify
        case (csr_op_i)
            CSR_SET:   csr_wval = csr_rdata_o | csr_wdata_i;
            CSR_CLEAR: csr_wval = csr_rdata_o & ~csr_wdata_i;
            default:   csr_wval = csr_wdata_i;
        endcase
    end

    // interrupt only against a valid head, illegal access otherwise
    always_comb begin : csr_trap
        csr_exception_o = '0;
        if (irq_i && commit_head_valid_i) begin
            csr_exception_o.valid = 1'b1;
            csr_exception_o.cause = CAUSE_M_EXT_INT;
        end else if (commit_csr_i && (!csr_known || (csr_we && csr_ro))) begin
            csr_exception_o.valid = 1'b1;
            csr_exception_o.cause = CAUSE_ILLEGAL_INSTR;
        end
    end

    // --------------------
    // state update
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtvec_q    <= '0;
        end else if (exception_i.valid) begin
            // a trap cancels any csr write of the same instruction
            mepc_q   <= commit_pc_i;
            mcause_q <= exception_i.cause;
        end else if (commit_csr_i && csr_we) begin
            if (csr_addr_i == CSR_MSCRATCH) begin
                mscratch_q <= csr_wval;
            end
            if (csr_addr_i == CSR_MTVEC) begin
                mtvec_q <= csr_wval;
            end
        end
    end

    // the commit stage issues csr strobes only for a valid head
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit_csr_i |-> commit_head_valid_i);

endmodule

// File: hw/regfile.sv
module regfile import commit_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [NR_COMMIT_PORTS-1:0][4:0]      waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0] wdata_i,
    input  logic [NR_COMMIT_PORTS-1:0]           we_i,
    input  logic [4:0]                           raddr_i,
    output logic [XLEN-1:0]                      rdata_o
);

    logic [XLEN-1:0] regs_q [32];

    // higher port index is the younger instruction, so its write lands last
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < 32; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                // x0 stays zero
                if (we_i[p] && (waddr_i[p] != 5'd0)) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // asynchronous read
    assign rdata_o = regs_q[raddr_i];

endmodule

// File: hw/retire_queue.sv
module retire_queue import commit_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              issue_valid_i,
    input  scoreboard_entry_t issue_entry_i,
    output logic              issue_ready_o,
    commit_if.queue           commit
);

    scoreboard_entry_t   mem_q [RQ_DEPTH];
    logic [RQ_PTR_W-1:0] rd_ptr_q;
    logic [RQ_PTR_W-1:0] wr_ptr_q;
    logic [RQ_PTR_W-1:0] rd_ptr_nxt;
    logic [RQ_PTR_W:0]   count_q;
    logic                push;
    logic [1:0]          pop_cnt;

    // no new entries while a trap flushes the queue
    assign issue_ready_o = (count_q < RQ_DEPTH) && !commit.flush;
    assign push          = issue_valid_i && issue_ready_o;
    assign pop_cnt       = {1'b0, commit.commit_ack[0]} + {1'b0, commit.commit_ack[1]};
    assign rd_ptr_nxt    = rd_ptr_q + 1'b1;

    // --------------------
    // head entries
    // --------------------
    // valid follows the fill level, not the stored bit
    always_comb begin : head
        commit.commit_instr[0]       = mem_q[rd_ptr_q];
        commit.commit_instr[0].valid = (count_q != '0);
        commit.commit_instr[1]       = mem_q[rd_ptr_nxt];
        commit.commit_instr[1].valid = (count_q > 1);
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= issue_entry_i;
        end
    end

    // pointers and fill level
    always_ff @(posedge clk_i) begin
        if (rst_i || commit.flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // zero, one or two entries leave per cycle
            rd_ptr_q <= rd_ptr_q + RQ_PTR_W'(pop_cnt);
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            count_q <= count_q + (RQ_PTR_W + 1)'(push) - (RQ_PTR_W + 1)'(pop_cnt);
        end
    end

    // --------------------
    // checks
    // --------------------
    // commit stage acks only slots that hold an entry
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit.commit_ack[0] |-> commit.commit_instr[0].valid);
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit.commit_ack[1] |-> commit.commit_instr[1].valid);

endmodule

// File: hw/store_commit_buffer.sv
module store_commit_buffer import commit_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic commit_lsu_i,
    output logic commit_lsu_ready_o,
    output logic no_st_pending_o,
    output logic drained_o
);

    logic [SB_CNT_W-1:0] count_q;
    logic [SB_TMR_W-1:0] timer_q;

    assign commit_lsu_ready_o = (count_q < SB_DEPTH);
    assign no_st_pending_o    = (count_q == '0);
    // front store leaves on the last cycle of its drain window
    assign drained_o = (count_q != '0) && (timer_q == SB_TMR_W'(SB_DRAIN_CYCLES - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
            timer_q <= '0;
        end else begin
            count_q <= count_q + SB_CNT_W'(commit_lsu_i) - SB_CNT_W'(drained_o);
            // timer restarts for the next store at the front
            if (drained_o || (count_q == '0)) begin
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + 1'b1;
            end
        end
    end

    // commit stage honours ready, so the buffer never overfills
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit_lsu_i |-> (count_q < SB_DEPTH));

endmodule

// File: run.sh
#!/bin/sh
# build and run the commit subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module commit_tb -o commit_sim
out=$(./obj_dir/commit_sim)
echo "$out"
# pass only when the testbench printed its pass line
echo "$out" | grep -qx "NO ERRORS"

// File: tb/commit_tb.sv
module commit_tb import commit_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic            clk_i;
    logic            rst_i;
    logic            issue_valid_i;
    logic [XLEN-1:0] issue_pc_i;
    fu_t             issue_fu_i;
    fu_op_t          issue_op_i;
    logic [4:0]      issue_rd_i;
    logic [XLEN-1:0] issue_result_i;
    logic            issue_ex_valid_i;
    logic [XLEN-1:0] issue_ex_cause_i;
    logic [XLEN-1:0] issue_ex_tval_i;
    logic            issue_ready_o;
    logic            halt_i;
    logic            single_step_i;
    logic            irq_i;
    logic [4:0]      rf_raddr_i;
    logic [XLEN-1:0] rf_rdata_o;
    logic [1:0]      retire_count_o;
    logic            store_drained_o;
    logic            fence_o;
    logic            exc_valid_o;
    logic [XLEN-1:0] exc_cause_o;
    logic [XLEN-1:0] mepc_o;
    logic [XLEN-1:0] mcause_o;
    logic [XLEN-1:0] csr_rdata_o;

    // --------------------
    // shadow state
    // --------------------
    // every accepted entry, oldest first
    scoreboard_entry_t pend_q[$];
    int              stores_done = 0;
    int              drains = 0;
    int              trap_count = 0;
    int              traps_checked = 0;
    logic [XLEN-1:0] last_cause = '0;
    // mscratch as the retired csr instructions left it
    logic [XLEN-1:0] mscratch_exp = '0;
    integer          seed = 32'h7095;
    int              n_records = 0;
    // driver and monitor keep their own error counts
    int              errs = 0;
    int              mon_errs = 0;
    int              base_errs = 0;
    int              n_pass = 0;
    int              n_fail = 0;
    logic [8*16-1:0] test_name = '0;

    commit_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_data(input string what, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("error %0s %0s: expected %h, actual %h", test_name, what, exp, act);
            errs++;
        end
    endtask

    task automatic check_exception(input exception_t exp, input exception_t act);
        if (act !== exp) begin
            $display("error %0s trap: expected valid %0b cause %h, actual valid %0b cause %h",
                     test_name, exp.valid, exp.cause, act.valid, act.cause);
            errs++;
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            $display("%0s: a test data record has missing fields", test_name);
            errs++;
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = 0;
        while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic push_instr(input logic [XLEN-1:0] pc, input fu_t fu, input fu_op_t op,
                              input logic [4:0] rd, input logic [XLEN-1:0] result,
                              input logic exv, input logic [XLEN-1:0] cause,
                              input logic [XLEN-1:0] tval);
        int   gap;
        logic taken;
        // random idle gap, no expected value depends on it
        gap = $unsigned($random(seed)) % 3;
        repeat (gap + 1) @(negedge clk_i);
        issue_valid_i    = 1'b1;
        issue_pc_i       = pc;
        issue_fu_i       = fu;
        issue_op_i       = op;
        issue_rd_i       = rd;
        issue_result_i   = result;
        issue_ex_valid_i = exv;
        issue_ex_cause_i = cause;
        issue_ex_tval_i  = tval;
        // hold until the queue takes it at a rising edge
        taken = 1'b0;
        while (!taken) begin
            #1;
            taken = issue_ready_o;
            @(negedge clk_i);
        end
        issue_valid_i = 1'b0;
    endtask

    // idle means every pushed entry has left and every committed store drained
    task automatic wait_idle();
        @(negedge clk_i);
        while (pend_q.size() != 0 || drains != stores_done) begin
            @(negedge clk_i);
        end
    endtask

    task automatic finish_test();
        int n;
        if (trap_count != traps_checked) begin
            $display("%0s: a trap was taken that the test did not expect", test_name);
            errs++;
            traps_checked = trap_count;
        end
        n = errs + mon_errs - base_errs;
        if (n == 0) begin
            $display("test %0s passed", test_name);
            n_pass++;
        end else begin
            $display("test %0s failed with %0d errors", test_name, n);
            n_fail++;
        end
        base_errs = errs + mon_errs;
    endtask

    // --------------------
    // monitor
    // --------------------
    // samples mid cycle, after the falling edge drive has settled
    always @(negedge clk_i) begin : monitor
        scoreboard_entry_t e;
        scoreboard_entry_t n;
        #1;
        if (!rst_i) begin
            if (halt_i && (retire_count_o != 0 || exc_valid_o)) begin
                $display("%0s: an instruction retired or trapped while halted", test_name);
                mon_errs++;
            end
            if (single_step_i && retire_count_o > 1) begin
                $display("%0s: two instructions retired in one single step cycle", test_name);
                mon_errs++;
            end
            if (fence_o && drains != stores_done) begin
                $display("%0s: fence retired while stores were still pending", test_name);
                mon_errs++;
            end
            if (int'(retire_count_o) > pend_q.size()) begin
                $display("%0s: more instructions retired than were issued", test_name);
                mon_errs++;
            end
            // a retiring mscratch access reads the old value
            if (retire_count_o != 0 && pend_q.size() > 0 && !exc_valid_o) begin
                e = pend_q[0];
                if (e.fu == CSR && e.ex.tval[11:0] == CSR_MSCRATCH) begin
                    check_data("csr read data", mscratch_exp, csr_rdata_o);
                    case (e.op)
                        CSR_WRITE: mscratch_exp = e.result;
                        CSR_SET:   mscratch_exp = mscratch_exp | e.result;
                        CSR_CLEAR: mscratch_exp = mscratch_exp & ~e.result;
                        default:   mscratch_exp = mscratch_exp;
                    endcase
                end
            end
            for (int i = 0; i < int'(retire_count_o) && pend_q.size() > 0; i++) begin
                e = pend_q.pop_front();
                // a trapping head is acked but commits nothing
                if (e.fu == STORE && !(i == 0 && exc_valid_o)) begin
                    stores_done++;
                end
            end
            // a trap drops all younger entries
            if (exc_valid_o) begin
                trap_count++;
                last_cause = exc_cause_o;
                pend_q.delete();
            end
            if (store_drained_o) begin
                drains++;
            end
            if (issue_valid_i && issue_ready_o) begin
                n = '{valid: 1'b1, pc: issue_pc_i, fu: issue_fu_i, op: issue_op_i,
                      rd: issue_rd_i, result: issue_result_i,
                      ex: '{valid: issue_ex_valid_i, cause: issue_ex_cause_i,
                            tval: issue_ex_tval_i}};
                pend_q.push_back(n);
            end
        end
    end

    initial begin : watchdog
        wait (n_records > 0);
        repeat (n_records * 40) @(posedge clk_i);
        $display("timeout: the run did not end within %0d cycles", n_records * 40);
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // driver
    // --------------------
    initial begin : driver
        int              fd;
        int              ch;
        int              code;
        int              lines;
        logic [8*16-1:0] tok;
        logic [8*8-1:0]  cmd;
        logic [XLEN-1:0] v0, v1, v2, v3, v4, v5, v6, v7;
        exception_t      exp_ex;
        exception_t      act_ex;
        rst_i            = 1'b1;
        issue_valid_i    = 1'b0;
        issue_pc_i       = '0;
        issue_fu_i       = NONE;
        issue_op_i       = ADD;
        issue_rd_i       = '0;
        issue_result_i   = '0;
        issue_ex_valid_i = 1'b0;
        issue_ex_cause_i = '0;
        issue_ex_tval_i  = '0;
        halt_i           = 1'b0;
        single_step_i    = 1'b0;
        irq_i            = 1'b0;
        rf_raddr_i       = '0;
        // line count sizes the watchdog
        lines = 0;
        fd = $fopen("tb/commit_testdata.txt", "r");
        if (fd != 0) begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == "\n") begin
                    lines++;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
        n_records = lines;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        fd = $fopen("tb/commit_testdata.txt", "r");
        while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                skip_line(fd);
            end else begin
                test_name = tok;
                code = $fscanf(fd, "%s", cmd);
                expect_fields(code, 1);
                case (cmd)
                    "push": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                       v0, v1, v2, v3, v4, v5, v6, v7);
                        expect_fields(code, 8);
                        push_instr(v0, fu_t'(v1[2:0]), fu_op_t'(v2[2:0]), v3[4:0], v4,
                                   v5[0], v6, v7);
                    end
                    "ctrl": begin
                        code = $fscanf(fd, "%h %h %h", v0, v1, v2);
                        expect_fields(code, 3);
                        @(negedge clk_i);
                        halt_i        = v0[0];
                        single_step_i = v1[0];
                        irq_i         = v2[0];
                    end
                    "idle": wait_idle();
                    "reg": begin
                        code = $fscanf(fd, "%h %h", v0, v1);
                        expect_fields(code, 2);
                        @(negedge clk_i);
                        rf_raddr_i = v0[4:0];
                        #1;
                        check_data($sformatf("x%0d", v0[4:0]), v1, rf_rdata_o);
                    end
                    "csr": begin
                        code = $fscanf(fd, "%h %h", v0, v1);
                        expect_fields(code, 2);
                        @(negedge clk_i);
                        check_data(v0[0] ? "mcause" : "mepc", v1, v0[0] ? mcause_o : mepc_o);
                    end
                    "trap": begin
                        code = $fscanf(fd, "%h %h", v0, v1);
                        expect_fields(code, 2);
                        @(negedge clk_i);
                        exp_ex = '{valid: v0[0], cause: v1, tval: '0};
                        act_ex = '{valid: trap_count != traps_checked,
                                   cause: (trap_count != traps_checked) ? last_cause : '0,
                                   tval: '0};
                        check_exception(exp_ex, act_ex);
                        traps_checked = trap_count;
                    end
                    "end": finish_test();
                    default: begin
                        $display("%0s: unknown command in the test data", test_name);
                        errs++;
                        skip_line(fd);
                    end
                endcase
            end
        end
        if (n_pass + n_fail == 0) begin
            $display("no test ran, the test data file is missing or empty");
            errs++;
        end
        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errs + mon_errs);
        if (errs + mon_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb/commit_testdata.txt
# columns: test command fields, all hex; push: pc fu op rd result ex_valid ex_cause ex_tval
# fu 1 alu 2 load 3 store 5 mult 6 csr; op 0 add 1 write 2 set 3 clear 4 fence
# ctrl: halt step irq; reg: rd value; csr: 0 mepc 1 mcause, value; trap: valid cause
basic ctrl 1 0 0
basic push 100 1 0 01 1111 0 0 0
basic push 104 2 0 01 3333 0 0 0
basic push 108 1 0 00 ffff 0 0 0
basic reg 01 0
basic ctrl 0 0 0
basic idle
basic reg 01 3333
basic reg 00 0
basic end
store ctrl 1 1 0
store push 200 1 0 0a aaaa 0 0 0
store push 204 5 0 0d dddd 0 0 0
store push 208 3 0 00 5000 0 0 0
store push 20c 3 0 00 5008 0 0 0
store push 210 3 0 00 5010 0 0 0
store push 214 4 0 0b bbbb 0 0 0
store push 218 0 4 00 0 0 0 0
store push 21c 2 0 0c cccc 0 0 0
store ctrl 0 1 0
store idle
store reg 0d dddd
store reg 0b bbbb
store reg 0c cccc
store ctrl 0 0 0
store end
csr push 300 6 1 05 1234 0 0 340
csr push 304 6 2 06 f0000 0 0 340
csr push 308 6 3 07 34 0 0 340
csr push 30c 6 0 08 0 0 0 340
csr idle
csr reg 06 1234
csr reg 07 f1234
csr reg 08 f1200
csr end
exc ctrl 1 0 0
exc push 404 2 0 15 22 1 5 abc
exc push 408 1 0 16 33 0 0 0
exc trap 0 0
exc ctrl 0 0 0
exc idle
exc trap 1 5
exc csr 0 404
exc csr 1 5
exc reg 16 0
exc end
illegal push 500 6 1 09 ab 0 0 7c0
illegal idle
illegal trap 1 2
illegal csr 0 500
illegal reg 09 0
illegal end
irq ctrl 0 0 1
irq push 600 1 0 18 55 1 2 0
irq idle
irq ctrl 0 0 0
irq trap 1 800000000000000b
irq csr 0 600
irq reg 18 0
irq end
